// ==== control_assert.sv ====
// ###################################################################
// control port assertions on strobes, enables and done pulses
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module control_assert (
    input logic clk,
    input logic reset,
    input logic byte_valid,
    input logic sys_reset,
    input logic cmd_error,
    input logic wdog_enable,
    input logic led_enable,
    input logic scratch_enable,
    input logic wdog_done,
    input logic led_done,
    input logic scratch_done
);
    a_byte_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        byte_valid |=> !byte_valid) else $error("byte_valid high two cycles in a row");

    a_sys_reset_pulse: assert property (@(posedge clk) disable iff (reset)
        sys_reset |=> !sys_reset) else $error("sys_reset high two cycles in a row");

    a_cmd_error_pulse: assert property (@(posedge clk) disable iff (reset)
        cmd_error |=> !cmd_error) else $error("cmd_error high two cycles in a row");

    a_one_enable: assert property (@(posedge clk) disable iff (reset)
        $onehot0({wdog_enable, led_enable, scratch_enable}))
        else $error("more than one handler enable high");

    // done comes the cycle after the last enable, never with it
    a_done_apart: assert property (@(posedge clk) disable iff (reset)
        !(wdog_done && wdog_enable) && !(led_done && led_enable) &&
        !(scratch_done && scratch_enable)) else $error("handler done while enabled");

endmodule

bind control_top control_assert i_assert (
    .clk            (clk),
    .reset          (reset),
    .byte_valid     (byte_valid),
    .sys_reset      (sys_reset),
    .cmd_error      (cmd_error),
    .wdog_enable    (wdog_enable),
    .led_enable     (led_enable),
    .scratch_enable (scratch_enable),
    .wdog_done      (wdog_done),
    .led_done       (led_done),
    .scratch_done   (scratch_done)
);

`default_nettype wire

// ==== control_cmd_capture.sv ====
// ###################################################################
// payload capture handler
// gathers bytes msb first and updates value on the last one
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module control_cmd_capture
    import ctrl_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       enable,
    output payload_t   value,
    output logic       done
);
    localparam int unsigned NUM_BYTES = num_bytes($bits(payload_t));
    localparam int unsigned CNT_W = $clog2(NUM_BYTES + 1);

    typedef logic [CNT_W-1:0] byte_count_t;

    payload_t    staging;
    payload_t    next_staging;
    byte_count_t bytes_left;
    logic        last_byte;

    assign next_staging = payload_t'({staging, data_in});
    assign last_byte = (bytes_left == byte_count_t'(1));

    // staging holds partial payloads, value only sees whole ones
    always_ff @(posedge clk) begin
        if (enable) staging <= next_staging;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            value <= '0;
            bytes_left <= byte_count_t'(NUM_BYTES);
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (enable) begin
                if (last_byte) begin
                    value <= next_staging;
                    bytes_left <= byte_count_t'(NUM_BYTES);
                    done <= 1'b1;
                end else begin
                    bytes_left <= bytes_left - byte_count_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== control_cmd_decoder.sv ====
// ###################################################################
// command decoder
// latches the opcode byte and steers payload bytes to one handler
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module control_cmd_decoder
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    input  logic       wdog_done,
    input  logic       led_done,
    input  logic       scratch_done,
    output logic [7:0] payload_data,
    output logic       wdog_enable,
    output logic       led_enable,
    output logic       scratch_enable,
    output logic       cmd_error
);
    typedef enum logic {
        ST_OPCODE,
        ST_PAYLOAD
    } dec_state_t;

    typedef enum logic [1:0] {
        SEL_WDOG,
        SEL_LED,
        SEL_SCRATCH
    } handler_sel_t;

    dec_state_t   state;
    handler_sel_t sel;
    logic         in_payload;
    logic         sel_done;

    assign in_payload = (state == ST_PAYLOAD);

    // payload bytes go to every handler, only one sees an enable
    assign payload_data = byte_data;
    assign wdog_enable = byte_valid && in_payload && (sel == SEL_WDOG);
    assign led_enable = byte_valid && in_payload && (sel == SEL_LED);
    assign scratch_enable = byte_valid && in_payload && (sel == SEL_SCRATCH);

    // done of the selected handler
    always_comb begin
        case (sel)
            SEL_WDOG:    sel_done = wdog_done;
            SEL_LED:     sel_done = led_done;
            SEL_SCRATCH: sel_done = scratch_done;
            default:     sel_done = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_OPCODE;
            sel <= SEL_WDOG;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                ST_OPCODE: begin
                    if (byte_valid) begin
                        case (byte_data)
                            OP_WATCHDOG_FEED: begin
                                sel <= SEL_WDOG;
                                state <= ST_PAYLOAD;
                            end
                            OP_LED_WRITE: begin
                                sel <= SEL_LED;
                                state <= ST_PAYLOAD;
                            end
                            OP_SCRATCH_WRITE: begin
                                sel <= SEL_SCRATCH;
                                state <= ST_PAYLOAD;
                            end
                            default: cmd_error <= 1'b1; // unknown, stay put
                        endcase
                    end
                end
                ST_PAYLOAD: begin
                    // handler counts its own bytes
                    if (sel_done) state <= ST_OPCODE;
                end
                default: state <= ST_OPCODE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== control_cmd_watchdog.sv ====
// ###################################################################
// watchdog handler
// reloads on a matching signature, pulses sys_reset on expiry
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module control_cmd_watchdog
    import ctrl_pkg::*;
#(
    parameter watchdog_pattern_t WATCHDOG_SIGNATURE = WATCHDOG_SIGNATURE_DEFAULT,
    parameter int unsigned       WATCHDOG_TICKS = WATCHDOG_TICKS_DEFAULT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       enable,
    output logic       sys_reset,
    output logic       done
);
    localparam int unsigned SIG_BYTES = num_bytes($bits(watchdog_pattern_t));
    localparam int unsigned TICK_W = $clog2(WATCHDOG_TICKS + 1);
    localparam int unsigned SIG_W = $clog2(SIG_BYTES + 1);

    typedef logic [TICK_W-1:0] tick_t;
    typedef logic [SIG_W-1:0]  sig_count_t;

    typedef enum logic {
        ST_SIG_CAPTURE,
        ST_DONE
    } wdog_state_t;

    wdog_state_t       state;
    watchdog_pattern_t cache;
    watchdog_pattern_t next_pattern;
    sig_count_t        sig_count;
    tick_t             tick_count;
    logic              feed_match;
    logic              expired;

    assign next_pattern = watchdog_pattern_t'({cache, data_in});
    assign feed_match = enable && (state == ST_SIG_CAPTURE) &&
                        (next_pattern == WATCHDOG_SIGNATURE);
    assign expired = (tick_count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_SIG_CAPTURE;
            cache <= '0;
            sig_count <= sig_count_t'(SIG_BYTES);
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_SIG_CAPTURE: begin
                    if (enable) begin
                        cache <= next_pattern;
                        if (sig_count == sig_count_t'(1)) begin
                            state <= ST_DONE;
                            done <= 1'b1;
                        end else begin
                            sig_count <= sig_count - sig_count_t'(1);
                        end
                    end
                end
                ST_DONE: begin
                    // fresh cache for the next feed
                    cache <= '0;
                    sig_count <= sig_count_t'(SIG_BYTES);
                    state <= ST_SIG_CAPTURE;
                end
                default: state <= ST_SIG_CAPTURE;
            endcase
        end
    end

    // free-running tick counter
    always_ff @(posedge clk) begin
        if (reset) begin
            tick_count <= tick_t'(WATCHDOG_TICKS);
            sys_reset <= 1'b0;
        end else begin
            sys_reset <= expired;
            if (feed_match || expired) tick_count <= tick_t'(WATCHDOG_TICKS);
            else tick_count <= tick_count - tick_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== control_top.sv ====
// ###################################################################
// control port top level
// uart receiver, command decoder and the three command handlers
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module control_top
    import ctrl_pkg::*;
#(
    parameter int unsigned       CLKS_PER_BIT = CLKS_PER_BIT_DEFAULT,
    parameter watchdog_pattern_t WATCHDOG_SIGNATURE = WATCHDOG_SIGNATURE_DEFAULT,
    parameter int unsigned       WATCHDOG_TICKS = WATCHDOG_TICKS_DEFAULT
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     rx,
    output led_t     led,
    output scratch_t scratch,
    output logic     sys_reset,
    output logic     cmd_error
);
    logic [7:0] byte_data;
    logic       byte_valid;
    logic [7:0] payload_data;
    logic       wdog_enable;
    logic       led_enable;
    logic       scratch_enable;
    logic       wdog_done;
    logic       led_done;
    logic       scratch_done;

    uart_byte_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    control_cmd_decoder i_decoder (
        .clk            (clk),
        .reset          (reset),
        .byte_data      (byte_data),
        .byte_valid     (byte_valid),
        .wdog_done      (wdog_done),
        .led_done       (led_done),
        .scratch_done   (scratch_done),
        .payload_data   (payload_data),
        .wdog_enable    (wdog_enable),
        .led_enable     (led_enable),
        .scratch_enable (scratch_enable),
        .cmd_error      (cmd_error)
    );

    control_cmd_watchdog #(
        .WATCHDOG_SIGNATURE (WATCHDOG_SIGNATURE),
        .WATCHDOG_TICKS     (WATCHDOG_TICKS)
    ) i_watchdog (
        .clk       (clk),
        .reset     (reset),
        .data_in   (payload_data),
        .enable    (wdog_enable),
        .sys_reset (sys_reset),
        .done      (wdog_done)
    );

    control_cmd_capture #(.payload_t(led_t)) i_led_capture (
        .clk     (clk),
        .reset   (reset),
        .data_in (payload_data),
        .enable  (led_enable),
        .value   (led),
        .done    (led_done)
    );

    control_cmd_capture #(.payload_t(scratch_t)) i_scratch_capture (
        .clk     (clk),
        .reset   (reset),
        .data_in (payload_data),
        .enable  (scratch_enable),
        .value   (scratch),
        .done    (scratch_done)
    );

endmodule

`default_nettype wire

// ==== ctrl_pkg.sv ====
// ###################################################################
// control port package
// opcodes, register types, parameter defaults and helpers
// ###################################################################
`default_nettype none

package ctrl_pkg;

    // command opcodes, first byte of every command
    localparam logic [7:0] OP_WATCHDOG_FEED = 8'h01;
    localparam logic [7:0] OP_LED_WRITE     = 8'h02;
    localparam logic [7:0] OP_SCRATCH_WRITE = 8'h03;

    // watchdog signature, sent most significant byte first
    typedef logic [31:0] watchdog_pattern_t;

    // handler registers
    typedef logic [7:0]  led_t;
    typedef logic [15:0] scratch_t;

    // top level defaults
    localparam watchdog_pattern_t WATCHDOG_SIGNATURE_DEFAULT = 32'hC0FFEE11;
    localparam int unsigned WATCHDOG_TICKS_DEFAULT = 100000; // about 2 ms at 50 MHz
    localparam int unsigned CLKS_PER_BIT_DEFAULT = 434;      // 115200 baud at 50 MHz

    // bytes needed to hold a given number of bits
    function automatic int unsigned num_bytes(input int unsigned bits);
        return (bits + 7) / 8;
    endfunction

endpackage

`default_nettype wire

// ==== project.f ====
ctrl_pkg.sv
uart_byte_rx.sv
control_cmd_decoder.sv
control_cmd_watchdog.sv
control_cmd_capture.sv
control_top.sv
control_assert.sv
tb_control_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the control port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_control_top -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_control_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_control_top.sv ====
// ###################################################################
// control port testbench
// drives uart commands into control_top and checks the registers
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_control_top
    import ctrl_pkg::*;
();
    localparam int CLKS_PER_BIT = 4;
    localparam int WDOG_TICKS = 600;
    localparam int FEED_GAP = 300;
    localparam int DRIVE_DELAY = 2;
    localparam int MAX_CYCLES = 20000; // traffic is about 4200 cycles

    logic     clk;
    logic     reset;
    logic     rx;
    led_t     led;
    scratch_t scratch;
    logic     sys_reset;
    logic     cmd_error;

    int seed = 76743;
    int cycle = 0;
    int reset_cycle = 0;
    int last_feed = 0;
    int checks = 0;
    int errors = 0;
    int err_pulses = 0;
    int sys_pulses[$];

    control_top #(
        .CLKS_PER_BIT   (CLKS_PER_BIT),
        .WATCHDOG_TICKS (WDOG_TICKS)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .led       (led),
        .scratch   (scratch),
        .sys_reset (sys_reset),
        .cmd_error (cmd_error)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // pulse monitor on the falling edge
    always @(negedge clk) begin
        if (sys_reset) sys_pulses.push_back(cycle);
        if (cmd_error) err_pulses++;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%0t check failed: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) $display("test %s: ok", name);
        else $display("test %s: %0d error(s)", name, errors - errors_before);
    endtask

    // start, eight data bits lsb first, stop and one idle bit
    task automatic send_byte(input logic [7:0] data);
        logic [10:0] frame;
        frame = {2'b11, data, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 11; i++) begin
            #DRIVE_DELAY rx = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        #DRIVE_DELAY;
    endtask

    task automatic send_cmd(input logic [7:0] opcode, input logic [31:0] payload,
                            input int nbytes);
        logic [7:0] b;
        send_byte(opcode);
        for (int i = nbytes - 1; i >= 0; i--) begin
            b = payload[8*i +: 8];
            send_byte(b);
        end
    endtask

    task automatic test_reset_state();
        int start_errors;
        start_errors = errors;
        check_value("led", 32'(led), 32'h0);
        check_value("scratch", 32'(scratch), 32'h0);
        check_value("cmd_error", 32'(cmd_error), 32'h0);
        check_value("sys_reset", 32'(sys_reset), 32'h0);
        while (sys_pulses.size() == 0) @(posedge clk);
        check_value("first sys_reset delay", sys_pulses[0] - reset_cycle, WDOG_TICKS + 1);
        @(negedge clk);
        check_value("sys_reset after pulse", 32'(sys_reset), 32'h0);
        report_test("reset_state", start_errors);
    endtask

    task automatic test_led_write();
        int start_errors;
        int rnd;
        scratch_t scratch_before;
        start_errors = errors;
        scratch_before = scratch;
        rnd = $random(seed);
        send_cmd(OP_LED_WRITE, {24'h0, rnd[7:0]}, 1);
        check_value("led", 32'(led), {24'h0, rnd[7:0]});
        check_value("scratch", 32'(scratch), 32'(scratch_before));
        report_test("led_write", start_errors);
    endtask

    task automatic test_scratch_write();
        int start_errors;
        int rnd;
        led_t led_before;
        start_errors = errors;
        led_before = led;
        repeat (2) begin
            rnd = $random(seed);
            send_cmd(OP_SCRATCH_WRITE, {16'h0, rnd[15:8], rnd[7:0]}, 2);
            check_value("scratch", 32'(scratch), int'(rnd[15:8]) * 256 + int'(rnd[7:0]));
            check_value("led", 32'(led), 32'(led_before));
        end
        report_test("scratch_write", start_errors);
    endtask

    task automatic test_watchdog_feed();
        int start_errors;
        int base;
        int start;
        start_errors = errors;
        start = cycle;
        send_cmd(OP_WATCHDOG_FEED, WATCHDOG_SIGNATURE_DEFAULT, 4);
        base = sys_pulses.size();
        repeat (7) begin
            while (cycle < start + FEED_GAP) @(posedge clk);
            start = cycle;
            send_cmd(OP_WATCHDOG_FEED, WATCHDOG_SIGNATURE_DEFAULT, 4);
        end
        last_feed = cycle;
        check_value("sys_reset pulses while fed", sys_pulses.size() - base, 0);
        report_test("watchdog_feed", start_errors);
    endtask

    task automatic test_watchdog_bad_feed();
        int start_errors;
        int base;
        int rnd;
        int delay;
        start_errors = errors;
        base = sys_pulses.size();
        repeat (3) begin
            rnd = $random(seed);
            // corrupt one of the four signature bytes
            send_cmd(OP_WATCHDOG_FEED,
                     WATCHDOG_SIGNATURE_DEFAULT ^ (32'h5A << (8 * rnd[1:0])), 4);
        end
        // full watchdog period after the last good feed
        while (sys_pulses.size() == base && cycle <= last_feed + WDOG_TICKS + 1) begin
            @(posedge clk);
        end
        check_true(sys_pulses.size() > base, "no sys_reset pulse after bad feeds");
        if (sys_pulses.size() > base) begin
            delay = sys_pulses[base] - last_feed;
            check_true(delay > 0 && delay <= WDOG_TICKS + 1,
                       "sys_reset not within watchdog period of last good feed");
        end
        report_test("watchdog_bad_feed", start_errors);
    endtask

    task automatic test_unknown_opcode();
        int start_errors;
        int err_before;
        int rnd;
        led_t led_before;
        scratch_t scratch_before;
        start_errors = errors;
        err_before = err_pulses;
        led_before = led;
        scratch_before = scratch;
        send_byte(8'h7E);
        check_value("cmd_error pulses", err_pulses - err_before, 1);
        check_value("led", 32'(led), 32'(led_before));
        check_value("scratch", 32'(scratch), 32'(scratch_before));
        rnd = $random(seed);
        send_cmd(OP_LED_WRITE, {24'h0, rnd[7:0]}, 1);
        check_value("led", 32'(led), {24'h0, rnd[7:0]});
        report_test("unknown_opcode", start_errors);
    endtask

    initial begin
        reset = 1'b1;
        rx = 1'b1;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY reset = 1'b0;
        reset_cycle = cycle;
        test_reset_state();
        test_led_write();
        test_scratch_write();
        test_watchdog_feed();
        test_watchdog_bad_feed();
        test_unknown_opcode();
        $display("checks passed: %0d, failed: %0d", checks - errors, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_byte_rx.sv ====
// ###################################################################
// uart receiver, 8N1, lsb first
// samples the rx line mid-bit and pulses byte_valid per good byte
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx #(
    parameter int unsigned CLKS_PER_BIT = 434
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_valid
);
    localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_count;
    logic [2:0]       bit_index;

    // two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            clk_count <= '0;
            bit_index <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            clk_count <= clk_count + CNT_W'(1);
            case (state)
                ST_IDLE: begin
                    clk_count <= '0;
                    bit_index <= '0;
                    if (!rx_sync) state <= ST_START;
                end
                ST_START: begin
                    if (clk_count == HALF_LAST) begin
                        clk_count <= '0;
                        state <= rx_sync ? ST_IDLE : ST_DATA; // glitch, not a start bit
                    end
                end
                ST_DATA: begin
                    if (clk_count == BIT_LAST) begin
                        clk_count <= '0;
                        byte_data <= {rx_sync, byte_data[7:1]};
                        bit_index <= bit_index + 3'd1;
                        if (bit_index == 3'd7) state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (clk_count == BIT_LAST) begin
                        byte_valid <= rx_sync; // low stop bit drops the byte
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
